// File: Makefile
# Verilator flow for the APB GPIO testbench

VERILATOR  ?= verilator
TOP        ?= tb_apb_gpio
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Done: no errors
VFLAGS     ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qxF "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/apb_gpio.sv
`timescale 1ns/10ps

module apb_gpio
#(
    parameter int PAD_NUM        = 32,
    parameter int APB_ADDR_WIDTH = 12
)
(
    input  logic                      HCLK,
    input  logic                      HRESETn,
    input  logic [APB_ADDR_WIDTH-1:0] PADDR,
    input  gpio_pkg::apb_data_t       PWDATA,
    input  logic                      PWRITE,
    input  logic                      PSEL,
    input  logic                      PENABLE,
    output gpio_pkg::apb_data_t       PRDATA,
    output logic                      PREADY,
    output logic                      PSLVERR,
    input  logic [PAD_NUM-1:0]        gpio_in,
    output logic [PAD_NUM-1:0]        gpio_out,
    output logic [PAD_NUM-1:0]        gpio_dir,
    output logic [PAD_NUM-1:0]        gpio_in_sync,
    output logic                      interrupt
);

    import gpio_pkg::*;

    reg_index_t              reg_index;
    logic [PAD_NUM-1:0]      gpio_en;
    logic [PAD_NUM-1:0]      inten;
    inttype_t [PAD_NUM-1:0]  inttype;
    logic                    status_rd;
    logic [PAD_NUM-1:0]      pad_in;
    logic [PAD_NUM-1:0]      pad_rise;
    logic [PAD_NUM-1:0]      pad_fall;
    logic [PAD_NUM-1:0]      status;

    if (PAD_NUM < 1 || PAD_NUM > MAX_PADS)
    begin : g_pad_num_check
        $error("PAD_NUM must be in 1..%0d", MAX_PADS);
    end

    assign reg_index = PADDR[6:2];  // Word index
    assign PREADY    = 1'b1;        // No wait states
    assign PSLVERR   = 1'b0;

    gpio_reg_file #(
        .PAD_NUM (PAD_NUM)
    ) u_reg_file (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .reg_index (reg_index),
        .PWDATA    (PWDATA),
        .PWRITE    (PWRITE),
        .PSEL      (PSEL),
        .PENABLE   (PENABLE),
        .pad_in    (pad_in),
        .status    (status),
        .PRDATA    (PRDATA),
        .gpio_out  (gpio_out),
        .gpio_dir  (gpio_dir),
        .gpio_en   (gpio_en),
        .inten     (inten),
        .inttype   (inttype),
        .status_rd (status_rd)
    );

    gpio_input_sync #(
        .PAD_NUM (PAD_NUM)
    ) u_input_sync (
        .HCLK     (HCLK),
        .HRESETn  (HRESETn),
        .gpio_in  (gpio_in),
        .gpio_en  (gpio_en),
        .pad_sync (gpio_in_sync),
        .pad_in   (pad_in),
        .pad_rise (pad_rise),
        .pad_fall (pad_fall)
    );

    gpio_irq_ctrl #(
        .PAD_NUM (PAD_NUM)
    ) u_irq_ctrl (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .pad_rise  (pad_rise),
        .pad_fall  (pad_fall),
        .inten     (inten),
        .gpio_en   (gpio_en),
        .inttype   (inttype),
        .status_rd (status_rd),
        .status    (status),
        .interrupt (interrupt)
    );

endmodule

// File: hdl/gpio_input_sync.sv
`timescale 1ns/10ps

module gpio_input_sync
#(
    parameter int PAD_NUM = 32
)
(
    input  logic               HCLK,
    input  logic               HRESETn,
    input  logic [PAD_NUM-1:0] gpio_in,
    input  logic [PAD_NUM-1:0] gpio_en,
    output logic [PAD_NUM-1:0] pad_sync,
    output logic [PAD_NUM-1:0] pad_in,
    output logic [PAD_NUM-1:0] pad_rise,
    output logic [PAD_NUM-1:0] pad_fall
);

    import gpio_pkg::*;

    localparam int NUM_GROUPS = (PAD_NUM + SYNC_GROUP - 1) / SYNC_GROUP;

    logic [PAD_NUM-1:0]    sync0;
    logic [NUM_GROUPS-1:0] grp_en;

    // One enable per group, stands in for a clock gate
    always_comb
    begin
        grp_en = '0;
        for (int i = 0; i < PAD_NUM; i++)
            if (gpio_en[i])
                grp_en[i / SYNC_GROUP] = 1'b1;
    end

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            sync0    <= '0;
            pad_sync <= '0;
            pad_in   <= '0;
        end
        else
        begin
            for (int i = 0; i < PAD_NUM; i++)
            begin
                if (grp_en[i / SYNC_GROUP])
                begin
                    sync0[i]    <= gpio_in[i];
                    pad_sync[i] <= sync0[i];
                    pad_in[i]   <= pad_sync[i];   // Edge reference
                end
            end
        end
    end

    assign pad_rise = pad_sync & ~pad_in;
    assign pad_fall = ~pad_sync & pad_in;

    a_edge_exclusive: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        (pad_rise & pad_fall) == '0
    );

endmodule

// File: hdl/gpio_irq_ctrl.sv
`timescale 1ns/10ps

module gpio_irq_ctrl
#(
    parameter int PAD_NUM = 32
)
(
    input  logic                              HCLK,
    input  logic                              HRESETn,
    input  logic [PAD_NUM-1:0]                pad_rise,
    input  logic [PAD_NUM-1:0]                pad_fall,
    input  logic [PAD_NUM-1:0]                inten,
    input  logic [PAD_NUM-1:0]                gpio_en,
    input  gpio_pkg::inttype_t [PAD_NUM-1:0]  inttype,
    input  logic                              status_rd,
    output logic [PAD_NUM-1:0]                status,
    output logic                              interrupt
);

    import gpio_pkg::*;

    logic [PAD_NUM-1:0] type_match;
    logic [PAD_NUM-1:0] irq_event;

    always_comb
    begin
        for (int i = 0; i < PAD_NUM; i++)
        begin
            case (inttype[i])
                INT_FALL: type_match[i] = pad_fall[i];
                INT_RISE: type_match[i] = pad_rise[i];
                INT_BOTH: type_match[i] = pad_rise[i] | pad_fall[i];
                default:  type_match[i] = 1'b0;   // Code 3 is silent
            endcase
        end
    end

    assign irq_event = type_match & inten & gpio_en;
    assign interrupt = |irq_event;

    // Sticky status where new events win over a clearing read
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
            status <= '0;
        else if (interrupt)
            status <= status | irq_event;
        else if (status_rd)
            status <= '0;
    end

    a_irq_enabled: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        interrupt |-> |(inten & gpio_en)
    );

endmodule

// File: hdl/gpio_pkg.sv
package gpio_pkg;

    typedef logic [31:0] apb_data_t;   // APB read/write word
    typedef logic [4:0]  reg_index_t;  // PADDR[6:2]
    typedef logic [1:0]  inttype_t;    // Edge type of one pad

    // Interrupt type codes, code 3 never fires
    localparam inttype_t INT_FALL = 2'd0;
    localparam inttype_t INT_RISE = 2'd1;
    localparam inttype_t INT_BOTH = 2'd2;

    localparam int MAX_PADS   = 32;
    localparam int SYNC_GROUP = 4;     // Pads per clock enable

    // Register word indexes
    localparam reg_index_t REG_PADDIR     = 5'h00;  // 0x00
    localparam reg_index_t REG_GPIOEN     = 5'h01;  // 0x04
    localparam reg_index_t REG_PADIN      = 5'h02;  // 0x08
    localparam reg_index_t REG_PADOUT     = 5'h03;  // 0x0C
    localparam reg_index_t REG_PADOUTSET  = 5'h04;  // 0x10
    localparam reg_index_t REG_PADOUTCLR  = 5'h05;  // 0x14
    localparam reg_index_t REG_INTEN      = 5'h06;  // 0x18
    localparam reg_index_t REG_INTTYPE_LO = 5'h07;  // 0x1C, pads 0..15
    localparam reg_index_t REG_INTTYPE_HI = 5'h08;  // 0x20, pads 16..31
    localparam reg_index_t REG_INTSTATUS  = 5'h09;  // 0x24

endpackage

// File: hdl/gpio_reg_file.sv
`timescale 1ns/10ps

module gpio_reg_file
#(
    parameter int PAD_NUM = 32
)
(
    input  logic                              HCLK,
    input  logic                              HRESETn,
    input  gpio_pkg::reg_index_t              reg_index,
    input  gpio_pkg::apb_data_t               PWDATA,
    input  logic                              PWRITE,
    input  logic                              PSEL,
    input  logic                              PENABLE,
    input  logic [PAD_NUM-1:0]                pad_in,
    input  logic [PAD_NUM-1:0]                status,
    output gpio_pkg::apb_data_t               PRDATA,
    output logic [PAD_NUM-1:0]                gpio_out,
    output logic [PAD_NUM-1:0]                gpio_dir,
    output logic [PAD_NUM-1:0]                gpio_en,
    output logic [PAD_NUM-1:0]                inten,
    output gpio_pkg::inttype_t [PAD_NUM-1:0]  inttype,
    output logic                              status_rd
);

    import gpio_pkg::*;

    logic               wr_en;
    logic               rd_en;
    logic [PAD_NUM-1:0] wr_bits;

    // Zero-extend a pad vector to a bus word
    function automatic apb_data_t pad_ext(input logic [PAD_NUM-1:0] v);
        apb_data_t w;
        w = '0;
        w[PAD_NUM-1:0] = v;
        return w;
    endfunction

    assign wr_en     = PSEL && PENABLE && PWRITE;   // Access phase only
    assign rd_en     = PSEL && PENABLE && !PWRITE;
    assign wr_bits   = PWDATA[PAD_NUM-1:0];
    assign status_rd = rd_en && (reg_index == REG_INTSTATUS);

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            gpio_dir <= '0;
            gpio_out <= '0;
            gpio_en  <= '0;
            inten    <= '0;
            inttype  <= '0;
        end
        else if (wr_en)
        begin
            case (reg_index)
                REG_PADDIR:    gpio_dir <= wr_bits;
                REG_GPIOEN:    gpio_en  <= wr_bits;
                REG_PADOUT:    gpio_out <= wr_bits;
                REG_PADOUTSET: gpio_out <= gpio_out | wr_bits;
                REG_PADOUTCLR: gpio_out <= gpio_out & ~wr_bits;
                REG_INTEN:     inten    <= wr_bits;
                REG_INTTYPE_LO:
                begin
                    for (int i = 0; i < PAD_NUM && i < 16; i++)
                        inttype[i] <= PWDATA[2*i +: 2];
                end
                REG_INTTYPE_HI:
                begin
                    for (int i = 16; i < PAD_NUM; i++)
                        inttype[i] <= PWDATA[2*(i-16) +: 2];
                end
                default:;      // PADIN, INTSTATUS, unmapped
            endcase
        end
    end

    always_comb
    begin
        PRDATA = '0;
        if (rd_en)
        begin
            case (reg_index)
                REG_PADDIR:    PRDATA = pad_ext(gpio_dir);
                REG_GPIOEN:    PRDATA = pad_ext(gpio_en);
                REG_PADIN:     PRDATA = pad_ext(pad_in);
                REG_PADOUT:    PRDATA = pad_ext(gpio_out);
                REG_INTEN:     PRDATA = pad_ext(inten);
                REG_INTSTATUS: PRDATA = pad_ext(status);
                REG_INTTYPE_LO:
                begin
                    for (int i = 0; i < PAD_NUM && i < 16; i++)
                        PRDATA[2*i +: 2] = inttype[i];
                end
                REG_INTTYPE_HI:
                begin
                    for (int i = 16; i < PAD_NUM; i++)
                        PRDATA[2*(i-16) +: 2] = inttype[i];
                end
                default:       PRDATA = '0;
            endcase
        end
    end

    // Bus stays quiet between reads
    a_prdata_idle: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        !(PSEL && PENABLE && !PWRITE) |-> (PRDATA == '0)
    );

endmodule

// File: sim.f
+incdir+include
hdl/gpio_pkg.sv
hdl/gpio_reg_file.sv
hdl/gpio_input_sync.sv
hdl/gpio_irq_ctrl.sv
hdl/apb_gpio.sv
sim/tb_apb_gpio.sv

// File: include/tb_gpio_tasks.svh
`ifndef TB_GPIO_TASKS_SVH
`define TB_GPIO_TASKS_SVH

task automatic apb_write(input reg_index_t idx, input apb_data_t data);
    @(posedge HCLK);
    PADDR   <= {5'b0, idx, 2'b00};   // Setup phase
    PWDATA  <= data;
    PWRITE  <= 1'b1;
    PSEL    <= 1'b1;
    PENABLE <= 1'b0;
    @(posedge HCLK);
    PENABLE <= 1'b1;
    @(posedge HCLK);
    PSEL    <= 1'b0;
    PENABLE <= 1'b0;
    PWRITE  <= 1'b0;
endtask

task automatic apb_read(input reg_index_t idx, output apb_data_t data);
    @(posedge HCLK);
    PADDR   <= {5'b0, idx, 2'b00};
    PWRITE  <= 1'b0;
    PSEL    <= 1'b1;
    PENABLE <= 1'b0;
    @(posedge HCLK);
    PENABLE <= 1'b1;
    @(negedge HCLK);
    data = PRDATA;                   // Mid access phase
    @(posedge HCLK);
    PSEL    <= 1'b0;
    PENABLE <= 1'b0;
endtask

task automatic check_data(input string name, input apb_data_t exp, input apb_data_t got);
    if (exp !== got)
    begin
        $display("ERR %s expected %08h got %08h", name, exp, got);
        errors++;
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic got);
    if (exp !== got)
    begin
        $display("ERR %s expected %0h got %0h", name, exp, got);
        errors++;
    end
endtask

task automatic report_test(input string name, input int errs_at_start);
    tests_run++;
    if (errors == errs_at_start)
        $display("%s: ok", name);
    else
        $display("%s: %0d error(s)", name, errors - errs_at_start);
endtask

// Edge rule per interrupt type
function automatic logic edge_fires(input inttype_t t, input logic rising);
    case (t)
        INT_FALL: return !rising;
        INT_RISE: return rising;
        INT_BOTH: return 1'b1;
        default:  return 1'b0;
    endcase
endfunction

// Expected pulses are one cycle wide, others must not show up at all
task automatic wait_interrupt(input logic expected, input string what);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < 20)
    begin
        @(negedge HCLK);
        seen = interrupt;
        cycles++;
    end
    if (expected && !seen)
    begin
        $display("Interrupt for %s never came within 20 cycles", what);
        errors++;
    end
    else if (!expected && seen)
    begin
        $display("Interrupt raised for %s although none was expected", what);
        errors++;
    end
    if (seen)
    begin
        @(negedge HCLK);
        check_bit("interrupt", 1'b0, interrupt);
    end
endtask

task automatic wait_padin(input apb_data_t expected);
    int        tries;
    apb_data_t rd;
    tries = 0;
    rd    = '0;
    while (tries < 10)
    begin
        apb_read(REG_PADIN, rd);
        if (rd === expected)
            break;
        tries++;
    end
    check_data("PADIN", expected, rd);
endtask

task automatic toggle_pad(input int pad);
    logic rising;
    logic hit;
    rising = !pad_lvl[pad];
    hit    = edge_fires(pad_type[pad], rising) && pad_inten[pad];
    @(posedge HCLK);
    gpio_in <= gpio_in ^ (apb_data_t'(1) << pad);
    pad_lvl[pad] = rising;
    wait_interrupt(hit, $sformatf("pad %0d %s", pad, rising ? "rise" : "fall"));
    if (hit)
        exp_status = exp_status | (apb_data_t'(1) << pad);
endtask

task automatic rw_check(input reg_index_t idx, input string name, input apb_data_t d);
    apb_data_t rd;
    apb_write(idx, d);
    apb_read(idx, rd);
    check_data(name, d, rd);
endtask

task automatic verify_reset();
    int        e0;
    apb_data_t rd;
    e0 = errors;
    @(negedge HCLK);
    check_bit("PREADY", 1'b1, PREADY);
    check_bit("PSLVERR", 1'b0, PSLVERR);
    check_bit("interrupt", 1'b0, interrupt);
    check_data("PRDATA", '0, PRDATA);
    for (int i = 0; i <= 9; i++)
    begin
        apb_read(reg_index_t'(i), rd);
        check_data($sformatf("PRDATA idx %0d", i), '0, rd);
    end
    apb_write(5'h0F, $random(seed));  // Unmapped
    apb_read(5'h0F, rd);
    check_data("PRDATA idx 15", '0, rd);
    apb_write(5'h1F, $random(seed));
    apb_read(5'h1F, rd);
    check_data("PRDATA idx 31", '0, rd);
    report_test("reset values", e0);
endtask

task automatic register_readback();
    int        e0;
    apb_data_t d;
    apb_data_t mask;
    apb_data_t model;
    apb_data_t rd;
    e0 = errors;
    d = $random(seed);
    rw_check(REG_PADDIR, "PADDIR", d);
    check_data("gpio_dir", d, gpio_dir);
    rw_check(REG_GPIOEN, "GPIOEN", $random(seed));
    rw_check(REG_INTEN, "INTEN", $random(seed));
    rw_check(REG_INTTYPE_LO, "INTTYPE_LO", $random(seed));
    rw_check(REG_INTTYPE_HI, "INTTYPE_HI", $random(seed));
    model = $random(seed);
    rw_check(REG_PADOUT, "PADOUT", model);
    check_data("gpio_out", model, gpio_out);
    mask = $random(seed);
    apb_write(REG_PADOUTSET, mask);
    model = model | mask;
    apb_read(REG_PADOUT, rd);
    check_data("PADOUT", model, rd);
    check_data("gpio_out", model, gpio_out);
    mask = $random(seed);
    apb_write(REG_PADOUTCLR, mask);
    model = model & ~mask;
    apb_read(REG_PADOUT, rd);
    check_data("PADOUT", model, rd);
    check_data("gpio_out", model, gpio_out);
    apb_write(REG_GPIOEN, '0);
    apb_write(REG_INTEN, '0);
    report_test("register access", e0);
endtask

task automatic input_group_enable();
    int        e0;
    apb_data_t p;
    e0 = errors;
    p  = $random(seed);
    apb_write(REG_GPIOEN, 32'h0000_0020);  // Pad 5, group of pads 4..7
    @(posedge HCLK);
    gpio_in <= p;
    wait_padin(p & 32'h0000_00F0);
    @(negedge HCLK);
    check_data("gpio_in_sync", p & 32'h0000_00F0, gpio_in_sync);
    apb_write(REG_GPIOEN, '1);
    wait_padin(p);
    @(negedge HCLK);
    check_data("gpio_in_sync", p, gpio_in_sync);
    pad_lvl = p;
    report_test("input groups", e0);
endtask

task automatic edge_interrupt_types();
    int e0;
    e0 = errors;
    @(posedge HCLK);
    gpio_in <= gpio_in & ~32'h0000_001F;   // Pads 0..4 start low
    pad_lvl = pad_lvl & ~32'h0000_001F;
    wait_padin(pad_lvl);
    pad_type[0] = INT_RISE;
    pad_type[1] = INT_FALL;
    pad_type[2] = INT_BOTH;
    pad_type[3] = 2'd3;
    pad_type[4] = INT_BOTH;                // Left masked by INTEN
    apb_write(REG_INTTYPE_LO, 32'h0000_02E1);
    pad_inten = 32'h0000_000F;
    apb_write(REG_INTEN, pad_inten);
    for (int pad = 0; pad <= 4; pad++)
    begin
        toggle_pad(pad);
        toggle_pad(pad);
    end
    report_test("edge interrupts", e0);
endtask

task automatic sticky_status();
    int        e0;
    apb_data_t rd;
    e0 = errors;
    apb_read(REG_INTSTATUS, rd);          // Start from a clean status
    exp_status = '0;
    toggle_pad(2);
    toggle_pad(0);
    toggle_pad(1);
    toggle_pad(1);
    toggle_pad(3);
    apb_read(REG_INTSTATUS, rd);
    check_data("INTSTATUS", exp_status, rd);
    apb_read(REG_INTSTATUS, rd);
    check_data("INTSTATUS", '0, rd);
    report_test("sticky status", e0);
endtask

`endif

// File: sim/tb_apb_gpio.sv
`timescale 1ns/10ps

module tb_apb_gpio;

    import gpio_pkg::*;

    localparam int PAD_NUM        = 32;
    localparam int APB_ADDR_WIDTH = 12;

    logic                      HCLK;
    logic                      HRESETn;
    logic [APB_ADDR_WIDTH-1:0] PADDR;
    apb_data_t                 PWDATA;
    logic                      PWRITE;
    logic                      PSEL;
    logic                      PENABLE;
    apb_data_t                 PRDATA;
    logic                      PREADY;
    logic                      PSLVERR;
    logic [PAD_NUM-1:0]        gpio_in;
    logic [PAD_NUM-1:0]        gpio_out;
    logic [PAD_NUM-1:0]        gpio_dir;
    logic [PAD_NUM-1:0]        gpio_in_sync;
    logic                      interrupt;

    integer    seed;
    int        errors;
    int        tests_run;
    apb_data_t exp_status;      // Expected INTSTATUS
    apb_data_t pad_lvl;         // Level currently driven on each pad
    apb_data_t pad_inten;
    inttype_t  pad_type [0:4];  // Types of the pads under test

    apb_gpio #(
        .PAD_NUM        (PAD_NUM),
        .APB_ADDR_WIDTH (APB_ADDR_WIDTH)
    ) DUT (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .PADDR        (PADDR),
        .PWDATA       (PWDATA),
        .PWRITE       (PWRITE),
        .PSEL         (PSEL),
        .PENABLE      (PENABLE),
        .PRDATA       (PRDATA),
        .PREADY       (PREADY),
        .PSLVERR      (PSLVERR),
        .gpio_in      (gpio_in),
        .gpio_out     (gpio_out),
        .gpio_dir     (gpio_dir),
        .gpio_in_sync (gpio_in_sync),
        .interrupt    (interrupt)
    );

    `include "tb_gpio_tasks.svh"

    initial
    begin
        HCLK = 1'b0;
        forever #2 HCLK = ~HCLK;   // 4 ns period
    end

    initial
    begin
        seed       = 32'hfe38;
        errors     = 0;
        tests_run  = 0;
        exp_status = '0;
        pad_lvl    = '0;
        pad_inten  = '0;
        HRESETn    = 1'b0;
        PADDR      = '0;
        PWDATA     = '0;
        PWRITE     = 1'b0;
        PSEL       = 1'b0;
        PENABLE    = 1'b0;
        gpio_in    = '0;
        repeat (10) @(posedge HCLK);
        HRESETn <= 1'b1;

        verify_reset();
        register_readback();
        input_group_enable();
        edge_interrupt_types();
        sticky_status();

        $display("Tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule
